/* sources.f */
+incdir+logic
logic/ntps_pkg.sv
logic/axi_lite_slave_if.sv
logic/network_path_regs.sv
logic/ntp_clock_select.sv
logic/ntps_interfaces.sv
tb/ntps_interfaces_assert.sv
tb/tb_ntps_interfaces.sv

/* Makefile */
# Verilator build for the NTPS interface testbench

TOP := tb_ntps_interfaces

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir

/* tb/tb_ntps_interfaces.sv */
// NTPS interface testbench
`timescale 1ns/1ps
`include "ntps_defines.svh"

module tb_ntps_interfaces;

  localparam int TIMEOUT = 50;
  localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

  logic axi_aclk = 1'b0;
  logic rst;
  ntps_pkg::addr_t awaddr;
  logic awvalid;
  logic awready;
  ntps_pkg::data_t wdata;
  ntps_pkg::strb_t wstrb;
  logic wvalid;
  logic wready;
  ntps_pkg::resp_t bresp;
  logic bvalid;
  logic bready;
  ntps_pkg::addr_t araddr;
  logic arvalid;
  logic arready;
  ntps_pkg::data_t rdata;
  ntps_pkg::resp_t rresp;
  logic rvalid;
  logic rready;
  ntps_pkg::ntp_src_t ntp_a;
  ntps_pkg::ntp_src_t ntp_b;
  ntps_pkg::ntp_time_t ntp_time;
  logic ntp_sync_ok;
  ntps_pkg::xphy_status_t xphy_status [`NTPS_NUM_PORTS];
  ntps_pkg::xphy_config_t xphy_config [`NTPS_NUM_PORTS];

  logic [31:0] lfsr_state;
  int err_value = 0;
  int err_proto = 0;
  int err_timeout = 0;
  int wr_handshakes = 0;
  int rd_handshakes = 0;

  // Stimulus table, one entry per index across the queues
  string           t_name  [$];
  bit              t_wr    [$];
  ntps_pkg::addr_t t_addr  [$];
  ntps_pkg::data_t t_wdata [$];
  ntps_pkg::strb_t t_strb  [$];
  ntps_pkg::data_t t_exp   [$];
  ntps_pkg::resp_t t_resp  [$];

  always #5 axi_aclk = ~axi_aclk;

  ntps_interfaces ntps_interfaces_inst (
    .axi_aclk (axi_aclk), .rst (rst),
    .awaddr (awaddr), .awvalid (awvalid), .awready (awready),
    .wdata (wdata), .wstrb (wstrb), .wvalid (wvalid), .wready (wready),
    .bresp (bresp), .bvalid (bvalid), .bready (bready),
    .araddr (araddr), .arvalid (arvalid), .arready (arready),
    .rdata (rdata), .rresp (rresp), .rvalid (rvalid), .rready (rready),
    .ntp_a (ntp_a), .ntp_b (ntp_b), .ntp_time (ntp_time), .ntp_sync_ok (ntp_sync_ok),
    .xphy_status (xphy_status), .xphy_config (xphy_config)
  );

  // Address handshakes, counted at the edge that accepts them
  always @(posedge axi_aclk) begin
    if (awvalid && wvalid && awready && wready) begin
      wr_handshakes++;
    end
    if (arvalid && arready) begin
      rd_handshakes++;
    end
  end

  // --------------------
  // Helpers
  // --------------------
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        out_bit;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      out_bit    = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (out_bit) lfsr_state = lfsr_state ^ LFSR_POLY;
      bits = {bits[30:0], out_bit};
    end
    return bits;
  endfunction

  function automatic ntps_pkg::addr_t reg_addr(input int win, input int ofs);
    return ntps_pkg::addr_t'((win << `NTPS_WIN_LSB) | (ofs << 2));
  endfunction

  // Byte lane mask built from the strobe
  function automatic ntps_pkg::data_t merge_bytes(input ntps_pkg::data_t old_word,
      input ntps_pkg::data_t new_word, input ntps_pkg::strb_t strb);
    ntps_pkg::data_t mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  task automatic add_entry(input string name, input bit is_wr, input ntps_pkg::addr_t addr,
      input ntps_pkg::data_t data, input ntps_pkg::strb_t strb,
      input ntps_pkg::data_t expected, input ntps_pkg::resp_t resp);
    t_name.push_back(name);
    t_wr.push_back(is_wr);
    t_addr.push_back(addr);
    t_wdata.push_back(data);
    t_strb.push_back(strb);
    t_exp.push_back(expected);
    t_resp.push_back(resp);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
      input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
      err_value++;
    end
  endtask

  // One bus transaction with a random stall on the response channel
  task automatic bus_xfer(input string name, input bit is_wr, input ntps_pkg::addr_t addr,
      input ntps_pkg::data_t data, input ntps_pkg::strb_t strb,
      output ntps_pkg::data_t got_data, output ntps_pkg::resp_t got_resp);
    int n;
    int hold;
    int wr_start;
    int rd_start;
    n = 0;
    hold = int'(take_bits(2));
    wr_start = wr_handshakes;
    rd_start = rd_handshakes;
    got_data = '0;
    got_resp = '0;
    @(negedge axi_aclk);
    if (is_wr) begin
      awaddr  = addr;
      wdata   = data;
      wstrb   = strb;
      awvalid = 1'b1;
      wvalid  = 1'b1;
    end else begin
      araddr  = addr;
      arvalid = 1'b1;
    end
    // Valid response means the address went in at the last edge
    do begin
      @(negedge axi_aclk);
      n++;
    end while (!(is_wr ? bvalid : rvalid) && n < TIMEOUT);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    arvalid = 1'b0;
    if (!(is_wr ? bvalid : rvalid)) begin
      $display("Timeout in %s: no response on the %s channel", name, is_wr ? "B" : "R");
      err_timeout++;
      return;
    end
    got_resp = is_wr ? bresp : rresp;
    got_data = is_wr ? '0 : rdata;
    repeat (hold) begin
      @(negedge axi_aclk);
      assert (is_wr ? (bvalid && bresp === got_resp)
                    : (rvalid && rresp === got_resp && rdata === got_data)) else begin
        $display("Response of %s dropped or changed while ready was low", name);
        err_proto++;
      end
    end
    bready = is_wr;
    rready = !is_wr;
    @(negedge axi_aclk);
    bready = 1'b0;
    rready = 1'b0;
    assert (!bvalid && !rvalid) else begin
      $display("Response of %s still valid after ready", name);
      err_proto++;
    end
    assert (wr_handshakes - wr_start == int'(is_wr)
            && rd_handshakes - rd_start == int'(!is_wr)) else begin
      $display("%s was not taken by exactly one address handshake", name);
      err_proto++;
    end
  endtask

  task automatic pulse_source(input bit use_b);
    @(negedge axi_aclk);
    if (use_b) ntp_b.upd = 1'b1;
    else ntp_a.upd = 1'b1;
    @(negedge axi_aclk);
    ntp_a.upd = 1'b0;
    ntp_b.upd = 1'b0;
    repeat (3) @(negedge axi_aclk);
  endtask

  // --------------------
  // Main sequence
  // --------------------
  initial begin
    ntps_pkg::data_t gc [`NTPS_NUM_PORTS];
    ntps_pkg::data_t sc [`NTPS_NUM_PORTS];
    ntps_pkg::data_t word;
    ntps_pkg::strb_t strb;
    ntps_pkg::data_t got_data;
    ntps_pkg::resp_t got_resp;
    ntps_pkg::ntp_time_t exp_time;
    int port;
    int ofs;

    lfsr_state = 32'hbd86;
    rst = 1'b1;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    // Both sources in sync while the register table runs
    ntp_a = '{time_val: '0, upd: 1'b0, sync_ok: 1'b1};
    ntp_b = '{time_val: '0, upd: 1'b0, sync_ok: 1'b1};
    for (int p = 0; p < `NTPS_NUM_PORTS; p++) begin
      xphy_status[p] = ntps_pkg::xphy_status_t'(take_bits(5));
    end
    repeat (4) @(negedge axi_aclk);
    rst = 1'b0;

    // Full writes, a partial config write, a write to read-only status
    for (int p = 0; p < `NTPS_NUM_PORTS; p++) begin
      gc[p] = take_bits(32);
      add_entry($sformatf("p%0d config write", p), 1'b1, reg_addr(p, `NTPS_REG_GEN_CONFIG),
                gc[p], 4'hf, gc[p], ntps_pkg::RESP_OKAY);
      sc[p] = take_bits(32);
      add_entry($sformatf("p%0d scratch write", p), 1'b1, reg_addr(p, `NTPS_REG_SCRATCH),
                sc[p], 4'hf, '0, ntps_pkg::RESP_OKAY);
      word = take_bits(32);
      strb = ntps_pkg::strb_t'(take_bits(4));
      gc[p] = merge_bytes(gc[p], word, strb);
      add_entry($sformatf("p%0d config partial", p), 1'b1, reg_addr(p, `NTPS_REG_GEN_CONFIG),
                word, strb, gc[p], ntps_pkg::RESP_OKAY);
      add_entry($sformatf("p%0d status write", p), 1'b1, reg_addr(p, `NTPS_REG_STATUS),
                take_bits(32), 4'hf, '0, ntps_pkg::RESP_OKAY);
    end
    // Windows without a bank
    for (int w = `NTPS_NUM_PORTS; w < (1 << `NTPS_WIN_W); w++) begin
      add_entry($sformatf("win%0d write", w), 1'b1, reg_addr(w, `NTPS_REG_GEN_CONFIG),
                take_bits(32), 4'hf, '0, ntps_pkg::RESP_SLVERR);
      add_entry($sformatf("win%0d read", w), 1'b0, reg_addr(w, `NTPS_REG_SCRATCH),
                '0, '0, '0, ntps_pkg::RESP_SLVERR);
    end
    for (int p = 0; p < `NTPS_NUM_PORTS; p++) begin
      add_entry($sformatf("p%0d config read", p), 1'b0, reg_addr(p, `NTPS_REG_GEN_CONFIG),
                '0, '0, gc[p], ntps_pkg::RESP_OKAY);
      add_entry($sformatf("p%0d scratch read", p), 1'b0, reg_addr(p, `NTPS_REG_SCRATCH),
                '0, '0, sc[p], ntps_pkg::RESP_OKAY);
      add_entry($sformatf("p%0d status read", p), 1'b0, reg_addr(p, `NTPS_REG_STATUS),
                '0, '0, {23'b0, 1'b1, 3'b0, xphy_status[p]}, ntps_pkg::RESP_OKAY);
      add_entry($sformatf("p%0d unknown read", p), 1'b0, reg_addr(p, 3 + 31 * p),
                '0, '0, '0, ntps_pkg::RESP_OKAY);
    end

    for (int i = 0; i < t_name.size(); i++) begin
      bus_xfer(t_name[i], t_wr[i], t_addr[i], t_wdata[i], t_strb[i], got_data, got_resp);
      check_value({t_name[i], " resp"}, 64'(t_resp[i]), 64'(got_resp));
      port = int'(t_addr[i][`NTPS_WIN_LSB +: `NTPS_WIN_W]);
      ofs  = int'(t_addr[i][2 +: `NTPS_OFS_W]);
      if (!t_wr[i]) begin
        check_value({t_name[i], " data"}, 64'(t_exp[i]), 64'(got_data));
      end else if (port < `NTPS_NUM_PORTS && ofs == `NTPS_REG_GEN_CONFIG) begin
        check_value({t_name[i], " xphy_config"},
                    64'(t_exp[i][`NTPS_XPHY_CFG_MSB:`NTPS_XPHY_CFG_LSB]),
                    64'(xphy_config[port]));
      end
    end

    // --------------------
    // Clock select
    // --------------------
    exp_time = '0;
    ntp_a = '{time_val: {take_bits(32), take_bits(32)}, upd: 1'b0, sync_ok: 1'b1};
    ntp_b = '{time_val: {take_bits(32), take_bits(32)}, upd: 1'b0, sync_ok: 1'b0};
    bus_xfer("select A write", 1'b1, reg_addr(0, `NTPS_REG_GEN_CONFIG), '0, 4'hf,
             got_data, got_resp);
    pulse_source(1'b1);
    check_value("select A ignores B time", exp_time, ntp_time);
    pulse_source(1'b0);
    exp_time = ntp_a.time_val;
    check_value("select A time", exp_time, ntp_time);
    check_value("select A sync", 64'(ntp_a.sync_ok), 64'(ntp_sync_ok));

    word = '0;
    word[`NTPS_CLK_SEL_BIT] = 1'b1;
    bus_xfer("select B write", 1'b1, reg_addr(0, `NTPS_REG_GEN_CONFIG), word, 4'hf,
             got_data, got_resp);
    pulse_source(1'b0);
    check_value("select B ignores A time", exp_time, ntp_time);
    pulse_source(1'b1);
    exp_time = ntp_b.time_val;
    check_value("select B time", exp_time, ntp_time);
    check_value("select B sync", 64'(ntp_b.sync_ok), 64'(ntp_sync_ok));

    // Status bit 8 follows the chosen source, now out of sync
    bus_xfer("select B status", 1'b0, reg_addr(1, `NTPS_REG_STATUS), '0, '0,
             got_data, got_resp);
    check_value("select B status", {23'b0, ntp_b.sync_ok, 3'b0, xphy_status[1]},
                64'(got_data));

    $display("Errors: value %0d, protocol %0d, timeout %0d",
             err_value, err_proto, err_timeout);
    if (err_value + err_proto + err_timeout == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* tb/ntps_interfaces_assert.sv */
// AXI4-Lite handshake assertions
`timescale 1ns/1ps

module ntps_interfaces_assert (
  input logic            axi_aclk,
  input logic            rst,
  input logic            awready,
  input logic            wready,
  input logic            arready,
  input logic            bvalid,
  input logic            bready,
  input ntps_pkg::resp_t bresp,
  input logic            rvalid,
  input logic            rready,
  input ntps_pkg::resp_t rresp,
  input ntps_pkg::data_t rdata
);

  // --------------------
  // Response channels
  // --------------------
  a_b_hold: assert property (@(posedge axi_aclk) disable iff (rst)
    bvalid && !bready |=> bvalid && $stable(bresp))
    else $error("B response dropped or changed before bready");

  a_r_hold: assert property (@(posedge axi_aclk) disable iff (rst)
    rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
    else $error("R response dropped or changed before rready");

  // One transaction at a time
  a_one_resp: assert property (@(posedge axi_aclk) disable iff (rst)
    !(bvalid && rvalid))
    else $error("B and R responses valid together");

  a_rst_ready: assert property (@(posedge axi_aclk)
    rst |-> !awready && !wready && !arready)
    else $error("Ready output high during reset");

endmodule

bind axi_lite_slave_if ntps_interfaces_assert ntps_interfaces_assert_inst (
  .axi_aclk (axi_aclk), .rst (rst),
  .awready (awready), .wready (wready), .arready (arready),
  .bvalid (bvalid), .bready (bready), .bresp (bresp),
  .rvalid (rvalid), .rready (rready), .rresp (rresp), .rdata (rdata)
);

/* logic/ntps_interfaces.sv */
// NTPS control interfaces top
`timescale 1ns/1ps
`include "ntps_defines.svh"

module ntps_interfaces (
  input  logic                   axi_aclk,
  input  logic                   rst,

  // AXI4-Lite slave port
  input  ntps_pkg::addr_t        awaddr,
  input  logic                   awvalid,
  output logic                   awready,
  input  ntps_pkg::data_t        wdata,
  input  ntps_pkg::strb_t        wstrb,
  input  logic                   wvalid,
  output logic                   wready,
  output ntps_pkg::resp_t        bresp,
  output logic                   bvalid,
  input  logic                   bready,
  input  ntps_pkg::addr_t        araddr,
  input  logic                   arvalid,
  output logic                   arready,
  output ntps_pkg::data_t        rdata,
  output ntps_pkg::resp_t        rresp,
  output logic                   rvalid,
  input  logic                   rready,

  // NTP clock sources and selected time
  input  ntps_pkg::ntp_src_t     ntp_a,
  input  ntps_pkg::ntp_src_t     ntp_b,
  output ntps_pkg::ntp_time_t    ntp_time,
  output logic                   ntp_sync_ok,

  // PHY status in, config out, one per port
  input  ntps_pkg::xphy_status_t xphy_status [`NTPS_NUM_PORTS],
  output ntps_pkg::xphy_config_t xphy_config [`NTPS_NUM_PORTS]
);

  ntps_pkg::reg_req_t req        [`NTPS_NUM_PORTS];
  ntps_pkg::data_t    rd_data    [`NTPS_NUM_PORTS];
  ntps_pkg::data_t    gen_config [`NTPS_NUM_PORTS];

  // --------------------
  // Bus front end
  // --------------------
  axi_lite_slave_if axi_lite_slave_if_inst (
    .axi_aclk (axi_aclk),
    .rst      (rst),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wstrb    (wstrb),
    .wvalid   (wvalid),
    .wready   (wready),
    .bresp    (bresp),
    .bvalid   (bvalid),
    .bready   (bready),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rresp    (rresp),
    .rvalid   (rvalid),
    .rready   (rready),
    .req      (req),
    .rd_data  (rd_data)
  );

  // --------------------
  // Per port banks
  // --------------------
  for (genvar p = 0; p < `NTPS_NUM_PORTS; p++) begin : g_port
    network_path_regs network_path_regs_inst (
      .axi_aclk    (axi_aclk),
      .rst         (rst),
      .req         (req[p]),
      .xphy_status (xphy_status[p]),
      .ntp_sync_ok (ntp_sync_ok),
      .rd_data     (rd_data[p]),
      .gen_config  (gen_config[p]),
      .xphy_config (xphy_config[p])
    );
  end

  // Port 0 config steers the shared clock
  ntp_clock_select ntp_clock_select_inst (
    .axi_aclk    (axi_aclk),
    .rst         (rst),
    .select      (gen_config[0][`NTPS_CLK_SEL_BIT]),
    .ntp_a       (ntp_a),
    .ntp_b       (ntp_b),
    .ntp_time    (ntp_time),
    .ntp_sync_ok (ntp_sync_ok)
  );

endmodule

/* logic/ntp_clock_select.sv */
// Common NTP clock select
`timescale 1ns/1ps

module ntp_clock_select (
  input  logic                axi_aclk,
  input  logic                rst,
  // Zero picks source A, one picks source B
  input  logic                select,
  input  ntps_pkg::ntp_src_t  ntp_a,
  input  ntps_pkg::ntp_src_t  ntp_b,
  output ntps_pkg::ntp_time_t ntp_time,
  output logic                ntp_sync_ok
);

  ntps_pkg::ntp_src_t  src;
  ntps_pkg::ntp_time_t time_q;
  logic                sync_ok_q;

  // --------------------
  // Source mux
  // --------------------
  assign src = select ? ntp_b : ntp_a;

  // --------------------
  // Output registers
  // --------------------
  // Time only moves on the chosen clock's update strobe,
  // the other source's strobes have no effect
  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      time_q    <= '0;
      sync_ok_q <= 1'b0;
    end else begin
      if (src.upd) begin
        time_q <= src.time_val;
      end
      sync_ok_q <= src.sync_ok;
    end
  end

  assign ntp_time    = time_q;
  assign ntp_sync_ok = sync_ok_q;

endmodule

/* logic/network_path_regs.sv */
// Network path register bank
`timescale 1ns/1ps
`include "ntps_defines.svh"

module network_path_regs (
  input  logic                   axi_aclk,
  input  logic                   rst,
  input  ntps_pkg::reg_req_t     req,
  input  ntps_pkg::xphy_status_t xphy_status,
  input  logic                   ntp_sync_ok,
  output ntps_pkg::data_t        rd_data,
  output ntps_pkg::data_t        gen_config,
  output ntps_pkg::xphy_config_t xphy_config
);

  ntps_pkg::data_t        gen_config_q;
  ntps_pkg::data_t        scratch_q;
  ntps_pkg::xphy_config_t xphy_config_q;
  ntps_pkg::data_t        status_word;
  ntps_pkg::data_t        read_word;

  // Merge the strobed byte lanes of new into old
  function automatic ntps_pkg::data_t apply_strb(
    input ntps_pkg::data_t old_word,
    input ntps_pkg::data_t new_word,
    input ntps_pkg::strb_t strb
  );
    ntps_pkg::data_t merged;
    merged = old_word;
    for (int b = 0; b < `NTPS_DATA_W / 8; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  // --------------------
  // Writable registers
  // --------------------
  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      gen_config_q  <= '0;
      scratch_q     <= '0;
      xphy_config_q <= '0;
    end else begin
      if (req.wr) begin
        case (req.ofs)
          ntps_pkg::ofs_t'(`NTPS_REG_GEN_CONFIG):
            gen_config_q <= apply_strb(gen_config_q, req.wdata, req.wstrb);
          ntps_pkg::ofs_t'(`NTPS_REG_SCRATCH):
            scratch_q <= apply_strb(scratch_q, req.wdata, req.wstrb);
          default: ;
        endcase
      end
      // PHY config trails gen_config by one cycle
      xphy_config_q <= gen_config_q[`NTPS_XPHY_CFG_MSB:`NTPS_XPHY_CFG_LSB];
    end
  end

  // --------------------
  // Read side
  // --------------------
  always_comb begin
    status_word      = '0;
    status_word[8]   = ntp_sync_ok;
    status_word[4:0] = xphy_status;
  end

  always_comb begin
    case (req.ofs)
      ntps_pkg::ofs_t'(`NTPS_REG_GEN_CONFIG): read_word = gen_config_q;
      ntps_pkg::ofs_t'(`NTPS_REG_STATUS):     read_word = status_word;
      ntps_pkg::ofs_t'(`NTPS_REG_SCRATCH):    read_word = scratch_q;
      default:                                read_word = '0;
    endcase
  end

  // Quiet unless addressed, the front end ORs all banks
  assign rd_data     = req.rd ? read_word : '0;
  assign gen_config  = gen_config_q;
  assign xphy_config = xphy_config_q;

endmodule

/* logic/axi_lite_slave_if.sv */
// AXI4-Lite register front end
`timescale 1ns/1ps
`include "ntps_defines.svh"

module axi_lite_slave_if (
  input  logic               axi_aclk,
  input  logic               rst,

  // Write address and data channels
  input  ntps_pkg::addr_t    awaddr,
  input  logic               awvalid,
  output logic               awready,
  input  ntps_pkg::data_t    wdata,
  input  ntps_pkg::strb_t    wstrb,
  input  logic               wvalid,
  output logic               wready,

  // Write response
  output ntps_pkg::resp_t    bresp,
  output logic               bvalid,
  input  logic               bready,

  // Read address and data
  input  ntps_pkg::addr_t    araddr,
  input  logic               arvalid,
  output logic               arready,
  output ntps_pkg::data_t    rdata,
  output ntps_pkg::resp_t    rresp,
  output logic               rvalid,
  input  logic               rready,

  // Register banks
  output ntps_pkg::reg_req_t req     [`NTPS_NUM_PORTS],
  input  ntps_pkg::data_t    rd_data [`NTPS_NUM_PORTS]
);

  // Word offset starts right above the byte lanes
  localparam int OFS_LSB = `NTPS_WIN_LSB - `NTPS_OFS_W;

  ntps_pkg::bus_state_t state_q;

  logic                 wr_accept;
  logic                 rd_accept;

  ntps_pkg::win_t       aw_win;
  ntps_pkg::win_t       ar_win;
  ntps_pkg::ofs_t       aw_ofs;
  ntps_pkg::ofs_t       ar_ofs;
  logic                 aw_mapped;
  logic                 ar_mapped;

  ntps_pkg::data_t      rd_word;
  ntps_pkg::data_t      rdata_q;
  ntps_pkg::resp_t      bresp_q;
  ntps_pkg::resp_t      rresp_q;

  // --------------------
  // Handshake
  // --------------------
  // Write takes priority on a tie
  assign wr_accept = (state_q == ntps_pkg::ST_IDLE) && awvalid && wvalid;
  assign rd_accept = (state_q == ntps_pkg::ST_IDLE) && arvalid && !wr_accept;

  assign awready = wr_accept;
  assign wready  = wr_accept;
  assign arready = rd_accept;

  assign bvalid = (state_q == ntps_pkg::ST_WRESP);
  assign rvalid = (state_q == ntps_pkg::ST_RRESP);
  assign bresp  = bresp_q;
  assign rresp  = rresp_q;
  assign rdata  = rdata_q;

  // --------------------
  // Address decode
  // --------------------
  assign aw_win = awaddr[`NTPS_WIN_LSB +: `NTPS_WIN_W];
  assign ar_win = araddr[`NTPS_WIN_LSB +: `NTPS_WIN_W];
  assign aw_ofs = awaddr[OFS_LSB +: `NTPS_OFS_W];
  assign ar_ofs = araddr[OFS_LSB +: `NTPS_OFS_W];

  // Windows past the last port have no bank behind them
  assign aw_mapped = (int'(aw_win) < `NTPS_NUM_PORTS);
  assign ar_mapped = (int'(ar_win) < `NTPS_NUM_PORTS);

  always_comb begin
    for (int i = 0; i < `NTPS_NUM_PORTS; i++) begin
      req[i].wr    = wr_accept && (int'(aw_win) == i);
      req[i].rd    = rd_accept && (int'(ar_win) == i);
      req[i].ofs   = wr_accept ? aw_ofs : ar_ofs;
      req[i].wdata = wdata;
      req[i].wstrb = wstrb;
    end
  end

  // Banks return zero unless their rd bit is set, so OR is the mux
  always_comb begin
    rd_word = '0;
    for (int i = 0; i < `NTPS_NUM_PORTS; i++) begin
      rd_word = rd_word | rd_data[i];
    end
  end

  // --------------------
  // Transaction FSM
  // --------------------
  always_ff @(posedge axi_aclk) begin
    if (rst) begin
      state_q <= ntps_pkg::ST_IDLE;
    end else begin
      case (state_q)
        ntps_pkg::ST_IDLE: begin
          if (wr_accept) begin
            state_q <= ntps_pkg::ST_WRESP;
          end else if (rd_accept) begin
            state_q <= ntps_pkg::ST_RRESP;
          end
        end
        ntps_pkg::ST_WRESP: begin
          if (bready) begin
            state_q <= ntps_pkg::ST_IDLE;
          end
        end
        ntps_pkg::ST_RRESP: begin
          if (rready) begin
            state_q <= ntps_pkg::ST_IDLE;
          end
        end
        default: state_q <= ntps_pkg::ST_IDLE;
      endcase
    end
  end

  // Response payload, held until the master takes it
  always_ff @(posedge axi_aclk) begin
    if (wr_accept) begin
      bresp_q <= aw_mapped ? ntps_pkg::RESP_OKAY : ntps_pkg::RESP_SLVERR;
    end
    if (rd_accept) begin
      rresp_q <= ar_mapped ? ntps_pkg::RESP_OKAY : ntps_pkg::RESP_SLVERR;
      rdata_q <= rd_word;
    end
  end

endmodule

/* logic/ntps_pkg.sv */
// NTPS interface types
`include "ntps_defines.svh"

package ntps_pkg;

  // --------------------
  // Bus vectors
  // --------------------
  typedef logic [`NTPS_ADDR_W-1:0]   addr_t;
  typedef logic [`NTPS_DATA_W-1:0]   data_t;
  typedef logic [`NTPS_DATA_W/8-1:0] strb_t;
  typedef logic [1:0]                resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Window index and word offset within a window
  typedef logic [`NTPS_WIN_W-1:0] win_t;
  typedef logic [`NTPS_OFS_W-1:0] ofs_t;

  // --------------------
  // Port side vectors
  // --------------------
  typedef logic [63:0] ntp_time_t;
  typedef logic [4:0]  xphy_status_t;
  typedef logic [`NTPS_XPHY_CFG_MSB-`NTPS_XPHY_CFG_LSB:0] xphy_config_t;

  // One NTP clock source as seen by the select
  typedef struct packed {
    ntp_time_t time_val;
    logic      upd;
    logic      sync_ok;
  } ntp_src_t;

  // Single-cycle request from the front end to one bank
  typedef struct packed {
    logic  wr;
    logic  rd;
    ofs_t  ofs;
    data_t wdata;
    strb_t wstrb;
  } reg_req_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRESP,
    ST_RRESP
  } bus_state_t;

endpackage

/* logic/ntps_defines.svh */
// NTPS interface constants
`ifndef NTPS_DEFINES_SVH
`define NTPS_DEFINES_SVH

// --------------------
// Sizes
// --------------------
`define NTPS_NUM_PORTS 4
`define NTPS_ADDR_W 32
`define NTPS_DATA_W 32

// Address split, 512 byte window per port
`define NTPS_WIN_LSB 9
`define NTPS_WIN_W 3
`define NTPS_OFS_W 7

// --------------------
// Register map
// --------------------
`define NTPS_REG_GEN_CONFIG 0
`define NTPS_REG_STATUS 1
`define NTPS_REG_SCRATCH 2

// Fields of the general config word
`define NTPS_CLK_SEL_BIT 24
`define NTPS_XPHY_CFG_MSB 31
`define NTPS_XPHY_CFG_LSB 29

`endif
